// File: Bender.yml
package:
  name: fft_8pt

dependencies: {}

sources:
  # RTL in compile order
  - files:
      - hw/fft_pkg.sv
      - hw/fft_cmul.sv
      - hw/fft_dif_stage.sv
      - hw/fft_8pt.sv

  # testbench
  - target: test
    files:
      - testbench/fft_8pt_sva.sv
      - testbench/fft_8pt_checker.sv
      - testbench/tb_fft_8pt.sv

// File: hw/fft_8pt.sv
module fft_8pt
    import fft_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W,
    parameter int FRAC_W = DEF_DATA_W - DEF_INT_W
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     valid_in,
    input  logic signed [DATA_W-1:0] x_re [FFT_N],
    input  logic signed [DATA_W-1:0] x_im [FFT_N],
    output logic                     valid_out,
    output logic signed [DATA_W-1:0] y_re [FFT_N],
    output logic signed [DATA_W-1:0] y_im [FFT_N]
);

    // reverse the low FFT_LOG2N bits of an index
    function automatic int bit_rev(input int idx);
        int rev;
        rev = 0;
        for (int b = 0; b < FFT_LOG2N; b++) begin
            rev = (rev << 1) | ((idx >> b) & 1);
        end
        return rev;
    endfunction

    // --------------------------------------------------------------------
    // inter-stage wires
    // --------------------------------------------------------------------

    logic                     s0_valid;
    logic signed [DATA_W-1:0] s0_re [FFT_N];
    logic signed [DATA_W-1:0] s0_im [FFT_N];

    logic                     s1_valid;
    logic signed [DATA_W-1:0] s1_re [FFT_N];
    logic signed [DATA_W-1:0] s1_im [FFT_N];

    logic                     s2_valid;
    logic signed [DATA_W-1:0] s2_re [FFT_N];
    logic signed [DATA_W-1:0] s2_im [FFT_N];

    // --------------------------------------------------------------------
    // three DIF stages, span halves each time
    // --------------------------------------------------------------------

    fft_dif_stage #(
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W),
        .SPAN      (4),
        .TW_STRIDE (1)
    ) u_stage0 (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (valid_in),
        .in_re     (x_re),
        .in_im     (x_im),
        .out_valid (s0_valid),
        .out_re    (s0_re),
        .out_im    (s0_im)
    );

    fft_dif_stage #(
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W),
        .SPAN      (2),
        .TW_STRIDE (2)
    ) u_stage1 (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (s0_valid),
        .in_re     (s0_re),
        .in_im     (s0_im),
        .out_valid (s1_valid),
        .out_re    (s1_re),
        .out_im    (s1_im)
    );

    // span 1 only uses W^0
    fft_dif_stage #(
        .DATA_W    (DATA_W),
        .FRAC_W    (FRAC_W),
        .SPAN      (1),
        .TW_STRIDE (4)
    ) u_stage2 (
        .clk       (clk),
        .reset_n   (reset_n),
        .in_valid  (s1_valid),
        .in_re     (s1_re),
        .in_im     (s1_im),
        .out_valid (s2_valid),
        .out_re    (s2_re),
        .out_im    (s2_im)
    );

    // --------------------------------------------------------------------
    // output reorder
    // --------------------------------------------------------------------

    assign valid_out = s2_valid;

    // DIF leaves bins bit-reversed, put them back in natural order
    for (genvar j = 0; j < FFT_N; j++) begin : g_reorder
        localparam int BIN = bit_rev(j);

        assign y_re[BIN] = s2_re[j];
        assign y_im[BIN] = s2_im[j];
    end

endmodule

// File: hw/fft_cmul.sv
module fft_cmul
    import fft_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W,
    parameter int FRAC_W = DEF_DATA_W - DEF_INT_W,
    parameter int TW_IDX = 0
) (
    input  logic signed [DATA_W-1:0] a_re,
    input  logic signed [DATA_W-1:0] a_im,
    output logic signed [DATA_W-1:0] p_re,
    output logic signed [DATA_W-1:0] p_im
);

    // --------------------------------------------------------------------
    // twiddle for this index
    // --------------------------------------------------------------------

    // one needs FRAC_W+1 magnitude bits plus sign
    localparam int TW_W = FRAC_W + 2;

    // full product width, one spare bit for the add
    localparam int PROD_W = DATA_W + TW_W + 1;

    localparam logic signed [TW_W-1:0] TW_ONE = TW_W'(2 ** FRAC_W);
    localparam logic signed [TW_W-1:0] TW_C = TW_W'(COS45_Q30 >>> (30 - FRAC_W));

    localparam logic signed [TW_W-1:0] W_RE =
        (TW_IDX == 0) ? TW_ONE :
        (TW_IDX == 1) ? TW_C :
        (TW_IDX == 2) ? TW_W'(0) :
        -TW_C;

    localparam logic signed [TW_W-1:0] W_IM =
        (TW_IDX == 0) ? TW_W'(0) :
        (TW_IDX == 1) ? -TW_C :
        (TW_IDX == 2) ? -TW_ONE :
        -TW_C;

    // --------------------------------------------------------------------
    // complex product
    // --------------------------------------------------------------------

    logic signed [PROD_W-1:0] prod_re;
    logic signed [PROD_W-1:0] prod_im;
    logic signed [PROD_W-1:0] scaled_re;
    logic signed [PROD_W-1:0] scaled_im;

    // (ac - bd) and (ad + bc), exact at PROD_W
    assign prod_re = a_re * W_RE - a_im * W_IM;
    assign prod_im = a_re * W_IM + a_im * W_RE;

    // drop the twiddle fraction, floor toward minus infinity
    assign scaled_re = prod_re >>> FRAC_W;
    assign scaled_im = prod_im >>> FRAC_W;

    // keep the low sample bits
    assign p_re = scaled_re[DATA_W-1:0];
    assign p_im = scaled_im[DATA_W-1:0];

endmodule

// File: hw/fft_dif_stage.sv
module fft_dif_stage
    import fft_pkg::*;
#(
    parameter int DATA_W    = DEF_DATA_W,
    parameter int FRAC_W    = DEF_DATA_W - DEF_INT_W,
    parameter int SPAN      = 4,
    parameter int TW_STRIDE = 1
) (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     in_valid,
    input  logic signed [DATA_W-1:0] in_re  [FFT_N],
    input  logic signed [DATA_W-1:0] in_im  [FFT_N],
    output logic                     out_valid,
    output logic signed [DATA_W-1:0] out_re [FFT_N],
    output logic signed [DATA_W-1:0] out_im [FFT_N]
);

    localparam int N_PAIRS = FFT_N / 2;

    // butterfly sums and differences, one entry per pair
    logic signed [DATA_W-1:0] sum_re  [N_PAIRS];
    logic signed [DATA_W-1:0] sum_im  [N_PAIRS];
    logic signed [DATA_W-1:0] diff_re [N_PAIRS];
    logic signed [DATA_W-1:0] diff_im [N_PAIRS];

    // next register contents, sums on the low index, rotated diffs on the high
    wire signed [DATA_W-1:0] nxt_re [FFT_N];
    wire signed [DATA_W-1:0] nxt_im [FFT_N];

    // --------------------------------------------------------------------
    // butterflies
    // --------------------------------------------------------------------

    for (genvar p = 0; p < N_PAIRS; p++) begin : g_pair
        // group of 2*SPAN points, pair offset inside it
        localparam int GRP = p / SPAN;
        localparam int POS = p % SPAN;
        localparam int LO  = GRP * 2 * SPAN + POS;
        localparam int HI  = LO + SPAN;
        localparam int TW  = POS * TW_STRIDE;

        // sums wrap at DATA_W
        assign sum_re[p]  = in_re[LO] + in_re[HI];
        assign sum_im[p]  = in_im[LO] + in_im[HI];
        assign diff_re[p] = in_re[LO] - in_re[HI];
        assign diff_im[p] = in_im[LO] - in_im[HI];

        assign nxt_re[LO] = sum_re[p];
        assign nxt_im[LO] = sum_im[p];

        fft_cmul #(
            .DATA_W (DATA_W),
            .FRAC_W (FRAC_W),
            .TW_IDX (TW)
        ) u_cmul (
            .a_re (diff_re[p]),
            .a_im (diff_im[p]),
            .p_re (nxt_re[HI]),
            .p_im (nxt_im[HI])
        );
    end

    // --------------------------------------------------------------------
    // stage register
    // --------------------------------------------------------------------

    // loads every cycle, the valid bit marks a frame
    always_ff @(posedge clk) begin
        if (!reset_n) begin
            out_valid <= 1'b0;
            for (int i = 0; i < FFT_N; i++) begin
                out_re[i] <= '0;
                out_im[i] <= '0;
            end
        end else begin
            out_valid <= in_valid;
            for (int i = 0; i < FFT_N; i++) begin
                out_re[i] <= nxt_re[i];
                out_im[i] <= nxt_im[i];
            end
        end
    end

endmodule

// File: hw/fft_pkg.sv
package fft_pkg;

    // --------------------------------------------------------------------
    // transform size
    // --------------------------------------------------------------------

    // points per frame
    localparam int FFT_N = 8;

    // butterfly stages, log2 of FFT_N
    localparam int FFT_LOG2N = 3;

    // --------------------------------------------------------------------
    // fixed-point format
    // --------------------------------------------------------------------

    // default width of each real and imaginary sample
    localparam int DEF_DATA_W = 18;

    // integer bits above the binary point, sign included
    // default fraction width is DEF_DATA_W - DEF_INT_W
    localparam int DEF_INT_W = 4;

    // --------------------------------------------------------------------
    // twiddle constant
    // --------------------------------------------------------------------

    // cos(pi/4) * 2**30, rounded
    localparam logic signed [31:0] COS45_Q30 = 32'sd759250125;

    // twiddles at fraction width F
    //   c   = COS45_Q30 >>> (30 - F)
    //   one = 2**F
    //   W^0 = ( one,  0  )
    //   W^1 = (  c,  -c  )
    //   W^2 = (  0, -one )
    //   W^3 = ( -c,  -c  )

endpackage

// File: testbench/fft_8pt_checker.sv
module fft_8pt_checker
    import fft_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W,
    parameter int FRAC_W = DEF_DATA_W - DEF_INT_W
) (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     valid_in,
    input logic signed [DATA_W-1:0] x_re [FFT_N],
    input logic signed [DATA_W-1:0] x_im [FFT_N],
    input logic                     valid_out,
    input logic signed [DATA_W-1:0] y_re [FFT_N],
    input logic signed [DATA_W-1:0] y_im [FFT_N]
);

    localparam int FRAME_W = 2 * FFT_N * DATA_W;

    logic [FRAME_W-1:0] frame_q [$];
    int error_count = 0;
    int frames_checked = 0;

    // ------------------------------------------------------------------
    // reference model
    // ------------------------------------------------------------------

    // two's complement wrap to the sample width
    function automatic longint wrap(input longint v);
        logic signed [DATA_W-1:0] w;
        w = v[DATA_W-1:0];
        return longint'(w);
    endfunction

    function automatic void twiddle(input int k, output longint w_re, output longint w_im);
        longint c;
        longint one;
        c = longint'(COS45_Q30) >>> (30 - FRAC_W);
        one = longint'(1) << FRAC_W;
        case (k)
            0: begin
                w_re = one;
                w_im = 0;
            end
            1: begin
                w_re = c;
                w_im = -c;
            end
            2: begin
                w_re = 0;
                w_im = -one;
            end
            default: begin
                w_re = -c;
                w_im = -c;
            end
        endcase
    endfunction

    function automatic int rev3(input int j);
        return ((j & 1) << 2) | (j & 2) | ((j >> 2) & 1);
    endfunction

    function automatic void ref_fft(input longint in_re [FFT_N], input longint in_im [FFT_N],
                                    output longint bin_re [FFT_N],
                                    output longint bin_im [FFT_N]);
        longint re [FFT_N];
        longint im [FFT_N];
        longint dr;
        longint di;
        longint wr;
        longint wi;
        int span;
        int lo;
        int hi;
        re = in_re;
        im = in_im;
        for (int s = 0; s < FFT_LOG2N; s++) begin
            span = FFT_N >> (s + 1);
            for (int g = 0; g < FFT_N; g += 2 * span) begin
                for (int i = 0; i < span; i++) begin
                    lo = g + i;
                    hi = lo + span;
                    twiddle(i * (1 << s), wr, wi);
                    dr = wrap(re[lo] - re[hi]);
                    di = wrap(im[lo] - im[hi]);
                    re[lo] = wrap(re[lo] + re[hi]);
                    im[lo] = wrap(im[lo] + im[hi]);
                    re[hi] = wrap((dr * wr - di * wi) >>> FRAC_W);
                    im[hi] = wrap((dr * wi + di * wr) >>> FRAC_W);
                end
            end
        end
        for (int j = 0; j < FFT_N; j++) begin
            bin_re[rev3(j)] = re[j];
            bin_im[rev3(j)] = im[j];
        end
    endfunction

    // ------------------------------------------------------------------
    // compare
    // ------------------------------------------------------------------

    task automatic compare_word(input string name, input int idx, input longint expected,
                                input longint actual);
        if (actual != expected) begin
            $display("** Error at time %0t: %s[%0d] expected %0d, got %0d",
                     $time, name, idx, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_frame();
        logic [FRAME_W-1:0] frame;
        longint in_re [FFT_N];
        longint in_im [FFT_N];
        longint exp_re [FFT_N];
        longint exp_im [FFT_N];
        if (frame_q.size() == 0) begin
            $display("error at time %0t: an output frame came out with no input frame pending",
                     $time);
            error_count++;
            return;
        end
        frame = frame_q.pop_front();
        for (int i = 0; i < FFT_N; i++) begin
            in_re[i] = longint'($signed(frame[2 * i * DATA_W +: DATA_W]));
            in_im[i] = longint'($signed(frame[(2 * i + 1) * DATA_W +: DATA_W]));
        end
        ref_fft(in_re, in_im, exp_re, exp_im);
        for (int b = 0; b < FFT_N; b++) begin
            compare_word("y_re", b, exp_re[b], longint'(y_re[b]));
            compare_word("y_im", b, exp_im[b], longint'(y_im[b]));
        end
        frames_checked++;
    endtask

    // all DUT signals change by NBA, so the edge sees settled values
    always @(posedge clk) begin
        logic [FRAME_W-1:0] frame;
        if (!reset_n) begin
            frame_q.delete();
        end else begin
            if (valid_out) begin
                check_frame();
            end
            if (valid_in) begin
                for (int i = 0; i < FFT_N; i++) begin
                    frame[2 * i * DATA_W +: DATA_W] = x_re[i];
                    frame[(2 * i + 1) * DATA_W +: DATA_W] = x_im[i];
                end
                frame_q.push_back(frame);
            end
        end
    end

endmodule

// File: testbench/fft_8pt_sva.sv
module fft_8pt_sva
    import fft_pkg::*;
#(
    parameter int DATA_W = DEF_DATA_W
) (
    input logic                     clk,
    input logic                     reset_n,
    input logic                     valid_in,
    input logic                     valid_out,
    input logic signed [DATA_W-1:0] y_re [FFT_N],
    input logic signed [DATA_W-1:0] y_im [FFT_N]
);

    int err_reset = 0;
    int err_delay = 0;
    int err_known = 0;

    // high while any y word carries an unknown bit
    logic y_unknown;

    always_comb begin
        y_unknown = 1'b0;
        for (int i = 0; i < FFT_N; i++) begin
            y_unknown = y_unknown | $isunknown(y_re[i]) | $isunknown(y_im[i]);
        end
    end

    a_low_after_reset: assert property (@(posedge clk) !reset_n |=> !valid_out)
        else begin
            $error("valid_out high in the cycle after reset");
            err_reset++;
        end

    // a frame needs three edges out of reset to reach valid_out
    a_valid_delay: assert property (@(posedge clk) disable iff (!reset_n)
        valid_out == ($past(valid_in, 3) && $past(reset_n, 3)
            && $past(reset_n, 2) && $past(reset_n, 1)))
        else begin
            $error("valid_out does not follow valid_in three cycles later");
            err_delay++;
        end

    a_y_known: assert property (@(posedge clk) disable iff (!reset_n)
        valid_out |-> !y_unknown)
        else begin
            $error("unknown bits on y while valid_out is high");
            err_known++;
        end

endmodule

// File: testbench/tb_fft_8pt.sv
module tb_fft_8pt
    import fft_pkg::*;
();

    localparam int DATA_W = DEF_DATA_W;
    localparam int FRAC_W = DEF_DATA_W - DEF_INT_W;
    localparam int LIM = 2 ** (DATA_W - 4);
    localparam int TIMEOUT_CYCLES = 200;
    localparam logic signed [DATA_W-1:0] MAX_POS = DATA_W'(LIM - 1);
    localparam logic signed [DATA_W-1:0] MAX_NEG = DATA_W'(1 - LIM);

    logic                     clk;
    logic                     reset_n;
    logic                     valid_in;
    logic signed [DATA_W-1:0] x_re [FFT_N];
    logic signed [DATA_W-1:0] x_im [FFT_N];
    logic                     valid_out;
    logic signed [DATA_W-1:0] y_re [FFT_N];
    logic signed [DATA_W-1:0] y_im [FFT_N];

    logic signed [DATA_W-1:0] frame_re [FFT_N];
    logic signed [DATA_W-1:0] frame_im [FFT_N];
    logic [31:0] rand_state;
    int frames_sent;
    int fail_count;
    int err_mark;

    initial clk = 1'b0;
    always #50 clk = ~clk;

    fft_8pt fft_8pt_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_in  (valid_in),
        .x_re      (x_re),
        .x_im      (x_im),
        .valid_out (valid_out),
        .y_re      (y_re),
        .y_im      (y_im)
    );

    fft_8pt_checker #(
        .DATA_W (DATA_W),
        .FRAC_W (FRAC_W)
    ) checker_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_in  (valid_in),
        .x_re      (x_re),
        .x_im      (x_im),
        .valid_out (valid_out),
        .y_re      (y_re),
        .y_im      (y_im)
    );

    bind fft_8pt fft_8pt_sva #(
        .DATA_W (DATA_W)
    ) sva_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .valid_in  (valid_in),
        .valid_out (valid_out),
        .y_re      (y_re),
        .y_im      (y_im)
    );

    // ------------------------------------------------------------------
    // helpers
    // ------------------------------------------------------------------

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // uniform in -(LIM-1) .. LIM-1
    function automatic logic signed [DATA_W-1:0] rand_sample();
        int r;
        rand_state = lcg_next(rand_state);
        r = int'({1'b0, rand_state[30:16]}) % (2 * LIM - 1);
        return DATA_W'(r - (LIM - 1));
    endfunction

    function automatic int total_errors();
        return checker_inst.error_count + fail_count
            + fft_8pt_inst.sva_inst.err_reset
            + fft_8pt_inst.sva_inst.err_delay
            + fft_8pt_inst.sva_inst.err_known;
    endfunction

    task automatic fill_random();
        for (int i = 0; i < FFT_N; i++) begin
            frame_re[i] = rand_sample();
            frame_im[i] = rand_sample();
        end
    endtask

    task automatic drive_frame();
        @(posedge clk);
        valid_in <= 1'b1;
        for (int i = 0; i < FFT_N; i++) begin
            x_re[i] <= frame_re[i];
            x_im[i] <= frame_im[i];
        end
        frames_sent++;
    endtask

    task automatic drive_gap();
        @(posedge clk);
        valid_in <= 1'b0;
    endtask

    task automatic apply_reset();
        @(posedge clk);
        reset_n <= 1'b0;
        valid_in <= 1'b0;
        repeat (2) @(posedge clk);
        reset_n <= 1'b1;
    endtask

    task automatic wait_frames(input string name);
        int cycles;
        cycles = 0;
        while (checker_inst.frames_checked < frames_sent && cycles < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        if (checker_inst.frames_checked < frames_sent) begin
            $display("test %s: timed out waiting for output frames", name);
            fail_count++;
        end
    endtask

    task automatic report_test(input int num, input string name);
        int errs;
        errs = total_errors() - err_mark;
        $display("test %0d %s: done, %0d errors", num, name, errs);
        err_mark = total_errors();
    endtask

    // ------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------

    initial begin
        reset_n = 1'b0;
        valid_in = 1'b0;
        for (int i = 0; i < FFT_N; i++) begin
            x_re[i] = '0;
            x_im[i] = '0;
        end
        rand_state = 32'h93e6;
        frames_sent = 0;
        fail_count = 0;
        err_mark = 0;
        repeat (4) @(posedge clk);
        reset_n <= 1'b1;

        // impulse at x0
        for (int i = 0; i < FFT_N; i++) begin
            frame_re[i] = '0;
            frame_im[i] = '0;
        end
        frame_re[0] = DATA_W'(1000);
        frame_im[0] = DATA_W'(-300);
        drive_frame();
        drive_gap();
        wait_frames("impulse");
        report_test(1, "impulse");

        // dc, energy only in bin 0
        for (int i = 0; i < FFT_N; i++) begin
            frame_re[i] = DATA_W'(1234);
            frame_im[i] = DATA_W'(-567);
        end
        drive_frame();
        drive_gap();
        wait_frames("dc");
        report_test(2, "dc");

        repeat (12) begin
            fill_random();
            drive_frame();
        end
        drive_gap();
        wait_frames("back to back");
        report_test(3, "back to back");

        repeat (10) begin
            fill_random();
            drive_frame();
            rand_state = lcg_next(rand_state);
            repeat (rand_state[17:16]) drive_gap();
        end
        drive_gap();
        wait_frames("random gaps");
        report_test(4, "random gaps");

        // two frames still in flight when reset hits
        repeat (2) begin
            fill_random();
            drive_frame();
        end
        apply_reset();
        frames_sent = checker_inst.frames_checked;
        repeat (4) drive_gap();
        fill_random();
        drive_frame();
        drive_gap();
        wait_frames("mid-stream reset");
        report_test(5, "mid-stream reset");

        // full-scale signs, patterns split at span 1, 2, 4, then uniform
        for (int p = 0; p < 5; p++) begin
            for (int i = 0; i < FFT_N; i++) begin
                frame_re[i] = (((i >> p) & 1) == 1 || p == 4) ? MAX_POS : MAX_NEG;
                frame_im[i] = (((i >> p) & 1) == 1) ? MAX_NEG : MAX_POS;
            end
            drive_frame();
        end
        repeat (4) begin
            for (int i = 0; i < FFT_N; i++) begin
                rand_state = lcg_next(rand_state);
                frame_re[i] = rand_state[20] ? MAX_POS : MAX_NEG;
                frame_im[i] = rand_state[21] ? MAX_POS : MAX_NEG;
            end
            drive_frame();
        end
        drive_gap();
        wait_frames("sign and twiddle");
        report_test(6, "sign and twiddle");

        $display("summary: 6 tests, %0d frames checked, %0d errors",
                 checker_inst.frames_checked, total_errors());
        if (total_errors() == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: vlog.f
hw/fft_pkg.sv
hw/fft_cmul.sv
hw/fft_dif_stage.sv
hw/fft_8pt.sv
testbench/fft_8pt_sva.sv
testbench/fft_8pt_checker.sv
testbench/tb_fft_8pt.sv
